/* include/csr_params.svh */
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Machine-mode CSR addresses
`define CSR_MSTATUS   12'h300
`define CSR_MIE       12'h304
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342

// Read-only counter halves
`define CSR_CYCLE     12'hC00
`define CSR_CYCLEH    12'hC80

// mstatus and mie bit positions
`define MSTATUS_MIE_BIT   3
`define MSTATUS_MPIE_BIT  7
`define MIE_MEIE_BIT      11

// Interrupt bit plus external machine interrupt code
`define MEI_CAUSE     32'h8000000B

// SYSTEM major opcode and the full mret word
`define OPCODE_SYSTEM 7'b1110011
`define INSTR_MRET    32'h30200073

`endif

/* hw/riscv_types_pkg.sv */
`default_nettype none

package riscv_types_pkg;

    // Data word, also used for pc and instruction
    typedef logic [31:0] word_t;

    // CSR address field, instr[31:20]
    typedef logic [11:0] csr_addr_t;

    // Register index for rd and rs1/zimm
    typedef logic [4:0] reg_idx_t;

    // Decoded CSR operation
    // Immediate forms fold into the same ops, the operand differs
    typedef enum logic [2:0] {
        CSR_NONE,
        CSR_RW,
        CSR_RS,
        CSR_RC,
        CSR_MRET
    } csr_op_e;

endpackage

`default_nettype wire

/* hw/trap_pkg.sv */
`default_nettype none

package trap_pkg;

    // Full mcause value, interrupt flag in the top bit
    typedef logic [31:0] cause_t;

    // Interrupt controller states
    // Save states run in order, one CSR write each
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SAVE_EPC,
        ST_SAVE_CAUSE,
        ST_SAVE_STATUS,
        ST_RESTORE
    } clint_state_e;

endpackage

`default_nettype wire

/* hw/csr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module csr_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  riscv_types_pkg::word_t    instr,
    input  riscv_types_pkg::word_t    rs1_data,
    input  riscv_types_pkg::word_t    csr_rd,
    input  logic                      csr_we_ex,
    input  riscv_types_pkg::csr_addr_t csr_wa_ex,
    input  riscv_types_pkg::word_t    csr_wd_ex,
    output riscv_types_pkg::csr_addr_t csr_ra_id,
    output logic                      d_valid,
    output riscv_types_pkg::csr_op_e  d_op,
    output riscv_types_pkg::csr_addr_t d_addr,
    output riscv_types_pkg::reg_idx_t d_rd,
    output riscv_types_pkg::word_t    d_operand,
    output riscv_types_pkg::word_t    d_old,
    output logic                      d_src_zero
);
    import riscv_types_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rd_field;
    reg_idx_t   rs1_field;
    csr_op_e    op_id;
    word_t      operand_id;
    word_t      old_id;

    // Instruction fields
    assign opcode    = instr[6:0];
    assign rd_field  = instr[11:7];
    assign funct3    = instr[14:12];
    assign rs1_field = instr[19:15];

    // CSR file read happens in ID
    assign csr_ra_id = instr[31:20];

    // Op decode, funct3[2] only picks the operand source
    always_comb begin
        op_id = CSR_NONE;
        if (opcode == `OPCODE_SYSTEM) begin
            if (instr == `INSTR_MRET) begin
                op_id = CSR_MRET;
            end else begin
                case (funct3[1:0])
                    2'b01:   op_id = CSR_RW;
                    2'b10:   op_id = CSR_RS;
                    2'b11:   op_id = CSR_RC;
                    default: op_id = CSR_NONE;
                endcase
            end
        end
    end

    // zimm is zero-extended
    assign operand_id = funct3[2] ? {27'b0, rs1_field} : rs1_data;

    // Bypass: EX writes at the coming edge, file still holds the stale value
    assign old_id = (csr_we_ex && (csr_wa_ex == csr_ra_id)) ? csr_wd_ex : csr_rd;

    // Only real CSR ops move on to EX
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= instr_valid && (op_id != CSR_NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            d_op       <= op_id;
            d_addr     <= csr_ra_id;
            d_rd       <= rd_field;
            d_operand  <= operand_id;
            d_old      <= old_id;
            d_src_zero <= (rs1_field == 5'd0);
        end
    end

    // EX never sees a bubble marked valid
    assert property (@(posedge clk) disable iff (rst) d_valid |-> (d_op != CSR_NONE));

endmodule

`default_nettype wire

/* hw/csr_exec.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module csr_exec (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       d_valid,
    input  riscv_types_pkg::csr_op_e   d_op,
    input  riscv_types_pkg::csr_addr_t d_addr,
    input  riscv_types_pkg::reg_idx_t  d_rd,
    input  riscv_types_pkg::word_t     d_operand,
    input  riscv_types_pkg::word_t     d_old,
    input  logic                       d_src_zero,
    output logic                       csr_we_ex,
    output riscv_types_pkg::csr_addr_t csr_wa_ex,
    output riscv_types_pkg::word_t     csr_wd_ex,
    output logic                       mret_ex,
    output logic                       rd_valid,
    output riscv_types_pkg::reg_idx_t  rd_index,
    output riscv_types_pkg::word_t     rd_data
);
    import riscv_types_pkg::*;

    word_t new_val;
    logic  op_writes;
    logic  addr_held;
    logic  ret_op;

    // New CSR value
    always_comb begin
        case (d_op)
            CSR_RW:  new_val = d_operand;
            CSR_RS:  new_val = d_old | d_operand;
            CSR_RC:  new_val = d_old & ~d_operand;
            default: new_val = d_old;
        endcase
    end

    // Registers that actually exist in the file
    // Keeps the ID bypass from forwarding into cycle or unknown addresses
    always_comb begin
        case (d_addr)
            `CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC,
            `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE: addr_held = 1'b1;
            default:                               addr_held = 1'b0;
        endcase
    end

    // Set/clear with x0 or zimm 0 is a pure read
    assign op_writes = (d_op == CSR_RW) ||
                       (((d_op == CSR_RS) || (d_op == CSR_RC)) && !d_src_zero);
    assign ret_op    = (d_op == CSR_MRET);

    // Priority write port, also the bypass source for ID
    assign csr_we_ex = d_valid && op_writes && addr_held;
    assign csr_wa_ex = d_addr;
    assign csr_wd_ex = new_val;

    // Result strobe and mret pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
            mret_ex  <= 1'b0;
        end else begin
            rd_valid <= d_valid && !ret_op;
            mret_ex  <= d_valid && ret_op;
        end
    end

    // Old value goes back to rd
    always_ff @(posedge clk) begin
        if (d_valid && !ret_op) begin
            rd_index <= d_rd;
            rd_data  <= d_old;
        end
    end

    // mret pulse lands in a cycle with no EX write, so the restore is not blocked
    assert property (@(posedge clk) disable iff (rst) !(csr_we_ex && mret_ex));

endmodule

`default_nettype wire

/* hw/csr_file.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module csr_file (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       csr_we_ex,
    input  riscv_types_pkg::csr_addr_t csr_wa_ex,
    input  riscv_types_pkg::word_t     csr_wd_ex,
    input  logic                       we_clint,
    input  riscv_types_pkg::csr_addr_t wa_clint,
    input  riscv_types_pkg::word_t     wd_clint,
    input  riscv_types_pkg::csr_addr_t csr_ra_id,
    output riscv_types_pkg::word_t     csr_rd,
    output riscv_types_pkg::word_t     clint_csr_mstatus,
    output riscv_types_pkg::word_t     clint_csr_mepc,
    output riscv_types_pkg::word_t     clint_csr_mtvec,
    output riscv_types_pkg::word_t     clint_csr_mie,
    output logic                       interrupt_enable
);
    import riscv_types_pkg::*;

    // Machine-mode registers
    logic [63:0] cycle_count;
    word_t       mtvec;
    word_t       mcause;
    word_t       mepc;
    word_t       mie;
    word_t       mstatus;
    word_t       mscratch;

    // Merged write port
    logic        we;
    csr_addr_t   wa;
    word_t       wd;

    // Free-running, never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_count <= 64'd0;
        end else begin
            cycle_count <= cycle_count + 64'd1;
        end
    end

    // EX first, controller only when EX is idle
    always_comb begin
        if (csr_we_ex) begin
            we = 1'b1;
            wa = csr_wa_ex;
            wd = csr_wd_ex;
        end else if (we_clint) begin
            we = 1'b1;
            wa = wa_clint;
            wd = wd_clint;
        end else begin
            we = 1'b0;
            wa = '0;
            wd = '0;
        end
    end

    // Unknown addresses drop the write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtvec    <= '0;
            mcause   <= '0;
            mepc     <= '0;
            mie      <= '0;
            mstatus  <= '0;
            mscratch <= '0;
        end else if (we) begin
            case (wa)
                `CSR_MTVEC:    mtvec    <= wd;
                `CSR_MCAUSE:   mcause   <= wd;
                `CSR_MEPC:     mepc     <= wd;
                `CSR_MIE:      mie      <= wd;
                `CSR_MSTATUS:  mstatus  <= wd;
                `CSR_MSCRATCH: mscratch <= wd;
                default:       ;
            endcase
        end
    end

    // ID read port, zero for anything unmapped
    always_comb begin
        case (csr_ra_id)
            `CSR_CYCLE:    csr_rd = cycle_count[31:0];
            `CSR_CYCLEH:   csr_rd = cycle_count[63:32];
            `CSR_MTVEC:    csr_rd = mtvec;
            `CSR_MCAUSE:   csr_rd = mcause;
            `CSR_MEPC:     csr_rd = mepc;
            `CSR_MIE:      csr_rd = mie;
            `CSR_MSTATUS:  csr_rd = mstatus;
            `CSR_MSCRATCH: csr_rd = mscratch;
            default:       csr_rd = '0;
        endcase
    end

    // Direct taps for the controller
    assign clint_csr_mstatus = mstatus;
    assign clint_csr_mepc    = mepc;
    assign clint_csr_mtvec   = mtvec;
    assign clint_csr_mie     = mie;

    // Global enable
    assign interrupt_enable  = mstatus[`MSTATUS_MIE_BIT];

endmodule

`default_nettype wire

/* hw/clint.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module clint (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       irq,
    input  riscv_types_pkg::word_t     pc,
    input  logic                       mret_ex,
    input  logic                       csr_we_ex,
    input  riscv_types_pkg::word_t     clint_csr_mstatus,
    input  riscv_types_pkg::word_t     clint_csr_mepc,
    input  riscv_types_pkg::word_t     clint_csr_mtvec,
    input  riscv_types_pkg::word_t     clint_csr_mie,
    input  logic                       interrupt_enable,
    output logic                       we_clint,
    output riscv_types_pkg::csr_addr_t wa_clint,
    output riscv_types_pkg::word_t     wd_clint,
    output logic                       redirect_valid,
    output riscv_types_pkg::word_t     redirect_pc
);
    import riscv_types_pkg::*;
    import trap_pkg::*;

    clint_state_e state;
    clint_state_e state_next;
    word_t        saved_pc;
    logic         irq_taken;
    logic         step;
    logic         finishing;

    // Global MIE and the MEIE bit both gate the line
    assign irq_taken = irq && interrupt_enable && clint_csr_mie[`MIE_MEIE_BIT];

    // Hold everything while EX owns the port
    assign step = !csr_we_ex;

    // Last write of either sequence goes through
    assign finishing = step && ((state == ST_SAVE_STATUS) || (state == ST_RESTORE));

    // mstatus edits start from the live value
    always_comb begin
        we_clint = 1'b1;
        wa_clint = `CSR_MSTATUS;
        wd_clint = clint_csr_mstatus;
        case (state)
            ST_SAVE_EPC: begin
                wa_clint = `CSR_MEPC;
                wd_clint = saved_pc;
            end
            ST_SAVE_CAUSE: begin
                wa_clint = `CSR_MCAUSE;
                wd_clint = cause_t'(`MEI_CAUSE);
            end
            ST_SAVE_STATUS: begin
                // Stash MIE in MPIE and mask further interrupts
                wd_clint[`MSTATUS_MPIE_BIT] = clint_csr_mstatus[`MSTATUS_MIE_BIT];
                wd_clint[`MSTATUS_MIE_BIT]  = 1'b0;
            end
            ST_RESTORE: begin
                wd_clint[`MSTATUS_MIE_BIT]  = clint_csr_mstatus[`MSTATUS_MPIE_BIT];
                wd_clint[`MSTATUS_MPIE_BIT] = 1'b1;
            end
            default: begin
                we_clint = 1'b0;
                wa_clint = '0;
                wd_clint = '0;
            end
        endcase
    end

    // mret wins over a pending interrupt
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (mret_ex) begin
                    state_next = ST_RESTORE;
                end else if (irq_taken) begin
                    state_next = ST_SAVE_EPC;
                end
            end
            ST_SAVE_EPC:    if (step) state_next = ST_SAVE_CAUSE;
            ST_SAVE_CAUSE:  if (step) state_next = ST_SAVE_STATUS;
            ST_SAVE_STATUS: if (step) state_next = ST_IDLE;
            ST_RESTORE:     if (step) state_next = ST_IDLE;
            default:        state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= ST_IDLE;
            redirect_valid <= 1'b0;
        end else begin
            state          <= state_next;
            redirect_valid <= finishing;
        end
    end

    // Trap pc capture and redirect target
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && !mret_ex && irq_taken) begin
            saved_pc <= pc;
        end
        if (finishing) begin
            redirect_pc <= (state == ST_RESTORE) ? clint_csr_mepc : clint_csr_mtvec;
        end
    end

    // Redirects never merge since each sequence writes at least once
    assert property (@(posedge clk) disable iff (rst) redirect_valid |=> !redirect_valid);

endmodule

`default_nettype wire

/* hw/csr_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      instr_valid,
    input  riscv_types_pkg::word_t    instr,
    input  riscv_types_pkg::word_t    rs1_data,
    input  riscv_types_pkg::word_t    pc,
    input  logic                      irq,
    output logic                      rd_valid,
    output riscv_types_pkg::reg_idx_t rd_index,
    output riscv_types_pkg::word_t    rd_data,
    output logic                      redirect_valid,
    output riscv_types_pkg::word_t    redirect_pc
);
    import riscv_types_pkg::*;

    // ID read port
    csr_addr_t csr_ra_id;
    word_t     csr_rd;

    // ID to EX
    logic      d_valid;
    csr_op_e   d_op;
    csr_addr_t d_addr;
    reg_idx_t  d_rd;
    word_t     d_operand;
    word_t     d_old;
    logic      d_src_zero;

    // EX write port, also the bypass
    logic      csr_we_ex;
    csr_addr_t csr_wa_ex;
    word_t     csr_wd_ex;
    logic      mret_ex;

    // Controller write port and CSR taps
    logic      we_clint;
    csr_addr_t wa_clint;
    word_t     wd_clint;
    word_t     clint_csr_mstatus;
    word_t     clint_csr_mepc;
    word_t     clint_csr_mtvec;
    word_t     clint_csr_mie;
    logic      interrupt_enable;

    // Port names match the wires one to one
    csr_decode csr_decode_inst (.*);
    csr_exec   csr_exec_inst   (.*);
    csr_file   csr_file_inst   (.*);
    clint      clint_inst      (.*);

endmodule

`default_nettype wire

/* tb/tb_csr_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "csr_params.svh"

module tb_csr_unit;
    import riscv_types_pkg::*;

    logic      clk;
    logic      rst;
    logic      instr_valid;
    word_t     instr;
    word_t     rs1_data;
    word_t     pc;
    logic      irq;
    logic      rd_valid;
    reg_idx_t  rd_index;
    word_t     rd_data;
    logic      redirect_valid;
    word_t     redirect_pc;

    // Reference CSR values by address
    word_t     model [0:4095];
    word_t     lfsr_state;
    word_t     last_rd_data;
    int        last_issue_cycle;
    int        tb_cycle;
    int        errors;
    int        tests_run;

    // Outstanding results in issue order
    word_t     exp_data [$];
    reg_idx_t  exp_index [$];
    int        exp_cycle [$];
    logic      exp_check [$];

    csr_unit csr_unit_inst (.*);

    always #2 clk = ~clk;

    // Edge counter that is read before its own update
    always @(posedge clk) tb_cycle <= tb_cycle + 1;

    task automatic check_word(input string name, input word_t got, input word_t expected);
        assert (got === expected) else begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1 with one step per bit
    function automatic word_t rand_bits(input int nbits);
        word_t value;
        int    i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    function automatic word_t csr_encode(input logic [2:0] funct3, input csr_addr_t addr,
                                         input reg_idx_t src, input reg_idx_t rd);
        return {addr, src, funct3, rd, `OPCODE_SYSTEM};
    endfunction

    // Registers that keep a written value
    function automatic logic model_holds(input csr_addr_t addr);
        case (addr)
            `CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC,
            `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE: return 1'b1;
            default:                               return 1'b0;
        endcase
    endfunction

    // Predict old value and new state and drive one instruction
    task automatic issue_csr(input logic [2:0] funct3, input csr_addr_t addr, input reg_idx_t src,
                             input reg_idx_t rd, input word_t rs1_val, input logic check);
        word_t operand;
        word_t old_val;
        word_t new_val;
        logic  writes;
        operand = funct3[2] ? {27'b0, src} : rs1_val;
        old_val = model[addr];
        case (funct3[1:0])
            2'b01:   new_val = operand;
            2'b10:   new_val = old_val | operand;
            default: new_val = old_val & ~operand;
        endcase
        // Set and clear with a zero source only read
        writes = (funct3[1:0] == 2'b01) || (src != 5'd0);
        if (writes && model_holds(addr)) begin
            model[addr] = new_val;
        end
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= csr_encode(funct3, addr, src, rd);
        rs1_data    <= rs1_val;
        last_issue_cycle = tb_cycle;
        exp_data.push_back(old_val);
        exp_index.push_back(rd);
        // Result registered two edges after the issue edge
        exp_cycle.push_back(tb_cycle + 3);
        exp_check.push_back(check);
    endtask

    task automatic stop_issue();
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while ((exp_data.size() > 0) && (waited < 20)) begin
            @(negedge clk);
            waited++;
        end
        if (exp_data.size() > 0) begin
            $display("Timeout: %0d results never arrived on rd_valid", exp_data.size());
            errors++;
            exp_data.delete();
            exp_index.delete();
            exp_cycle.delete();
            exp_check.delete();
        end
    endtask

    task automatic run_one(input logic [2:0] funct3, input csr_addr_t addr, input reg_idx_t src,
                           input reg_idx_t rd, input word_t rs1_val);
        issue_csr(funct3, addr, src, rd, rs1_val, 1'b1);
        stop_issue();
        wait_results();
    endtask

    task automatic wait_redirect(input word_t target);
        int waited;
        waited = 0;
        while (!redirect_valid && (waited < 30)) begin
            @(negedge clk);
            waited++;
        end
        if (redirect_valid) begin
            check_word("redirect_pc", redirect_pc, target);
        end else begin
            $display("Timeout: redirect_valid never pulsed");
            errors++;
        end
    endtask

    task automatic watch_no_redirect(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge clk);
            if (redirect_valid) begin
                $display("Unexpected redirect_valid while the interrupt is masked");
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - start);
        end
    endtask

    // Compare every rd_valid against the oldest prediction
    always @(negedge clk) begin
        if (!rst && rd_valid) begin
            if (exp_data.size() == 0) begin
                $display("Unexpected rd_valid with no instruction outstanding");
                errors++;
            end else begin
                last_rd_data = rd_data;
                if (exp_check[0]) begin
                    check_word("rd_data", rd_data, exp_data[0]);
                end
                check_word("rd_index", word_t'(rd_index), word_t'(exp_index[0]));
                check_word("rd_valid cycle", word_t'(tb_cycle), word_t'(exp_cycle[0]));
                exp_data.delete(0);
                exp_index.delete(0);
                exp_cycle.delete(0);
                exp_check.delete(0);
            end
        end
    end

    task automatic reset_and_counter();
        csr_addr_t addrs [8];
        word_t     c1;
        word_t     c2;
        int        s1;
        int        s2;
        int        n;
        int        start;
        start = errors;
        addrs = '{`CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC, `CSR_MSCRATCH,
                  `CSR_MEPC, `CSR_MCAUSE, `CSR_CYCLEH, 12'h7C0};
        for (n = 0; n < 8; n++) begin
            issue_csr(3'b010, addrs[n], 5'd0, reg_idx_t'(n + 1), rand_bits(32), 1'b1);
        end
        stop_issue();
        wait_results();
        // Counter delta equals issue distance
        issue_csr(3'b010, `CSR_CYCLE, 5'd0, 5'd1, 32'd0, 1'b0);
        s1 = last_issue_cycle;
        stop_issue();
        wait_results();
        c1 = last_rd_data;
        repeat (3 + rand_bits(3)) @(posedge clk);
        issue_csr(3'b010, `CSR_CYCLE, 5'd0, 5'd2, 32'd0, 1'b0);
        s2 = last_issue_cycle;
        stop_issue();
        wait_results();
        c2 = last_rd_data;
        check_word("cycle delta", c2 - c1, word_t'(s2 - s1));
        report_test("reset_and_counter", start);
    endtask

    task automatic read_modify_write();
        csr_addr_t addrs [6];
        int        n;
        int        start;
        start = errors;
        addrs = '{`CSR_MSTATUS, `CSR_MIE, `CSR_MTVEC, `CSR_MSCRATCH, `CSR_MEPC, `CSR_MCAUSE};
        for (n = 0; n < 6; n++) begin
            run_one(3'b001, addrs[n], 5'd1, reg_idx_t'(rand_bits(5)), rand_bits(32));
            run_one(3'b010, addrs[n], 5'd2, reg_idx_t'(rand_bits(5)), rand_bits(32));
            run_one(3'b011, addrs[n], 5'd3, reg_idx_t'(rand_bits(5)), rand_bits(32));
            run_one(3'b101, addrs[n], reg_idx_t'(rand_bits(5)), 5'd9, 32'd0);
            run_one(3'b110, addrs[n], reg_idx_t'(rand_bits(5)), 5'd10, 32'd0);
            run_one(3'b111, addrs[n], reg_idx_t'(rand_bits(5)), 5'd11, 32'd0);
            // Value must survive an x0 source
            run_one(3'b010, addrs[n], 5'd0, 5'd12, rand_bits(32));
            run_one(3'b010, addrs[n], 5'd0, 5'd13, 32'd0);
        end
        // Unmapped address drops writes
        run_one(3'b001, 12'h7C0, 5'd1, 5'd14, rand_bits(32));
        run_one(3'b010, 12'h7C0, 5'd0, 5'd15, 32'd0);
        report_test("read_modify_write", start);
    endtask

    task automatic back_to_back_forwarding();
        int n;
        int start;
        start = errors;
        for (n = 0; n < 4; n++) begin
            issue_csr(3'b001, `CSR_MSCRATCH, 5'd1, reg_idx_t'(n + 1), rand_bits(32), 1'b1);
        end
        issue_csr(3'b010, `CSR_MSCRATCH, 5'd2, 5'd6, rand_bits(32), 1'b1);
        issue_csr(3'b011, `CSR_MSCRATCH, 5'd3, 5'd7, rand_bits(32), 1'b1);
        issue_csr(3'b010, `CSR_MSCRATCH, 5'd0, 5'd8, 32'd0, 1'b1);
        // Dropped write to an unmapped address is never forwarded
        issue_csr(3'b001, 12'h7C0, 5'd1, 5'd9, rand_bits(32), 1'b1);
        issue_csr(3'b010, 12'h7C0, 5'd0, 5'd10, 32'd0, 1'b1);
        stop_issue();
        wait_results();
        report_test("back_to_back_forwarding", start);
    endtask

    task automatic interrupt_entry();
        word_t vec;
        word_t trap_pc;
        word_t st;
        int    start;
        start = errors;
        vec     = rand_bits(30) << 2;
        trap_pc = rand_bits(30) << 2;
        run_one(3'b001, `CSR_MTVEC, 5'd1, 5'd2, vec);
        run_one(3'b001, `CSR_MIE, 5'd1, 5'd2, word_t'(1) << `MIE_MEIE_BIT);
        run_one(3'b001, `CSR_MSTATUS, 5'd1, 5'd2, word_t'(1) << `MSTATUS_MIE_BIT);
        @(posedge clk);
        pc  <= trap_pc;
        irq <= 1'b1;
        wait_redirect(vec);
        @(posedge clk);
        irq <= 1'b0;
        // Trap entry effects on the model
        st = model[`CSR_MSTATUS];
        st[`MSTATUS_MPIE_BIT] = st[`MSTATUS_MIE_BIT];
        st[`MSTATUS_MIE_BIT]  = 1'b0;
        model[`CSR_MSTATUS] = st;
        model[`CSR_MEPC]    = trap_pc;
        model[`CSR_MCAUSE]  = `MEI_CAUSE;
        run_one(3'b010, `CSR_MEPC, 5'd0, 5'd3, 32'd0);
        check_word("mepc", last_rd_data, trap_pc);
        run_one(3'b010, `CSR_MCAUSE, 5'd0, 5'd4, 32'd0);
        check_word("mcause", last_rd_data, `MEI_CAUSE);
        run_one(3'b010, `CSR_MSTATUS, 5'd0, 5'd5, 32'd0);
        check_word("mstatus.MIE", word_t'(last_rd_data[`MSTATUS_MIE_BIT]), 32'd0);
        check_word("mstatus.MPIE", word_t'(last_rd_data[`MSTATUS_MPIE_BIT]), 32'd1);
        report_test("interrupt_entry", start);
    endtask

    task automatic mret_return();
        word_t st;
        int    start;
        start = errors;
        st = model[`CSR_MSTATUS];
        st[`MSTATUS_MIE_BIT]  = st[`MSTATUS_MPIE_BIT];
        st[`MSTATUS_MPIE_BIT] = 1'b1;
        model[`CSR_MSTATUS] = st;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= `INSTR_MRET;
        rs1_data    <= 32'd0;
        stop_issue();
        wait_redirect(model[`CSR_MEPC]);
        run_one(3'b010, `CSR_MSTATUS, 5'd0, 5'd6, 32'd0);
        check_word("mstatus.MIE", word_t'(last_rd_data[`MSTATUS_MIE_BIT]), 32'd1);
        check_word("mstatus.MPIE", word_t'(last_rd_data[`MSTATUS_MPIE_BIT]), 32'd1);
        report_test("mret_return", start);
    endtask

    task automatic interrupt_masking();
        int start;
        start = errors;
        // Global MIE off
        run_one(3'b111, `CSR_MSTATUS, 5'(1 << `MSTATUS_MIE_BIT), 5'd7, 32'd0);
        @(posedge clk);
        irq <= 1'b1;
        watch_no_redirect(24);
        @(posedge clk);
        irq <= 1'b0;
        // MIE back on with MEIE off
        run_one(3'b110, `CSR_MSTATUS, 5'(1 << `MSTATUS_MIE_BIT), 5'd8, 32'd0);
        run_one(3'b011, `CSR_MIE, 5'd6, 5'd9, word_t'(1) << `MIE_MEIE_BIT);
        @(posedge clk);
        irq <= 1'b1;
        watch_no_redirect(24);
        @(posedge clk);
        irq <= 1'b0;
        report_test("interrupt_masking", start);
    endtask

    // Hang guard
    initial begin
        #100000;
        $display("Simulation watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int i;
        clk              = 1'b0;
        rst              = 1'b1;
        instr_valid      = 1'b0;
        instr            = '0;
        rs1_data         = '0;
        pc               = '0;
        irq              = 1'b0;
        lfsr_state       = 32'h9505d2a7;
        last_rd_data     = '0;
        last_issue_cycle = 0;
        tb_cycle         = 0;
        errors           = 0;
        tests_run        = 0;
        for (i = 0; i < 4096; i++) begin
            model[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        reset_and_counter();
        read_modify_write();
        back_to_back_forwarding();
        interrupt_entry();
        mret_return();
        interrupt_masking();
        $display("Tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
hw/riscv_types_pkg.sv
hw/trap_pkg.sv
hw/csr_decode.sv
hw/csr_exec.sv
hw/csr_file.sv
hw/clint.sv
hw/csr_unit.sv
tb/tb_csr_unit.sv

/* Makefile */
TOP := tb_csr_unit

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
